//--- src/nts_disp_pkg.sv
// Shared widths, register map, bank states and bus structs, referenced by scoped name
package nts_disp_pkg;

  // ------------------------------
  // Widths and depths
  // ------------------------------
  localparam int BUF_ADDR_W = 5;                // 32 words per bank
  localparam int BUF_DEPTH  = 1 << BUF_ADDR_W;
  localparam int WORD_W     = 64;
  localparam int MASK_W     = 8;
  localparam int CNT_W      = 64;
  localparam int API_ADDR_W = 12;
  localparam int API_DATA_W = 32;

  localparam logic [63:0] CORE_NAME    = 64'h4e_54_53_2d_44_49_53_50; // NTS-DISP
  localparam logic [31:0] CORE_VERSION = 32'h30_2e_30_32;             // 0.02

  // ------------------------------
  // Register map
  // ------------------------------
  localparam logic [API_ADDR_W-1:0] ADDR_NAME0          = 12'h000;
  localparam logic [API_ADDR_W-1:0] ADDR_NAME1          = 12'h001;
  localparam logic [API_ADDR_W-1:0] ADDR_VERSION        = 12'h002;
  localparam logic [API_ADDR_W-1:0] ADDR_BYTES_RX_MSB   = 12'h00a;
  localparam logic [API_ADDR_W-1:0] ADDR_BYTES_RX_LSB   = 12'h00b;
  localparam logic [API_ADDR_W-1:0] ADDR_FRAMES_MSB     = 12'h020;
  localparam logic [API_ADDR_W-1:0] ADDR_FRAMES_LSB     = 12'h021;
  localparam logic [API_ADDR_W-1:0] ADDR_GOOD_MSB       = 12'h022;
  localparam logic [API_ADDR_W-1:0] ADDR_GOOD_LSB       = 12'h023;
  localparam logic [API_ADDR_W-1:0] ADDR_BAD_MSB        = 12'h024;
  localparam logic [API_ADDR_W-1:0] ADDR_BAD_LSB        = 12'h025;
  localparam logic [API_ADDR_W-1:0] ADDR_DISPATCHED_MSB = 12'h026;
  localparam logic [API_ADDR_W-1:0] ADDR_DISPATCHED_LSB = 12'h027;
  localparam logic [API_ADDR_W-1:0] ADDR_ERROR_MSB      = 12'h028;
  localparam logic [API_ADDR_W-1:0] ADDR_ERROR_LSB      = 12'h029;

  // Statistics counter slots
  localparam int         NUM_CNT        = 6;
  localparam logic [2:0] CNT_FRAMES     = 3'd0;
  localparam logic [2:0] CNT_GOOD       = 3'd1;
  localparam logic [2:0] CNT_BAD        = 3'd2;
  localparam logic [2:0] CNT_DISPATCHED = 3'd3;
  localparam logic [2:0] CNT_ERROR      = 3'd4;
  localparam logic [2:0] CNT_BYTES      = 3'd5;

  typedef enum logic [3:0] {
    EMPTY,
    HAS_DATA,
    PACKET_RECEIVED,
    OUT_INIT_0,
    OUT_INIT_1,
    OUT_STREAM,
    OUT_FIN_0,
    OUT_FIN_1,
    ERROR_GENERAL
  } buf_state_e;

  typedef struct packed {
    logic [WORD_W-1:0] data;
    logic [MASK_W-1:0] valid;
    logic              good;
    logic              bad;
  } mac_rx_t;

  typedef struct packed {
    logic [WORD_W-1:0] data;      // Byte reversed and masked
    logic [3:0]        bytes;     // 0 to 8
    logic              any_valid;
    logic              sof;
  } rx_word_t;

  typedef struct packed {
    logic                  we;
    logic                  bank;
    logic [BUF_ADDR_W-1:0] addr;
    logic [WORD_W-1:0]     data;
  } buf_wr_t;

  typedef struct packed {
    logic                  bank;
    logic [BUF_ADDR_W-1:0] addr;
    logic                  emit;
  } buf_rd_t;

  typedef struct packed {
    logic       sof;
    logic       good;
    logic       bad;
    logic       dispatched;
    logic       error;
    logic [3:0] bytes;
  } stat_events_t;

endpackage

//--- src/rx_frontend.sv
// MAC receive front end that reorders bytes, counts them and flags start of frame
`timescale 1ns/1ps

module rx_frontend (
  input  logic                    i_clk,
  input  logic                    i_areset,
  input  nts_disp_pkg::mac_rx_t   i_mac,
  output nts_disp_pkg::rx_word_t  o_word
);

  logic [nts_disp_pkg::MASK_W-1:0] prev_valid_q;
  logic [3:0]                      bytes;

  // Only masks filled from the low end count
  always_comb
  begin
    case (i_mac.valid)
      8'b1111_1111: bytes = 4'd8;
      8'b0111_1111: bytes = 4'd7;
      8'b0011_1111: bytes = 4'd6;
      8'b0001_1111: bytes = 4'd5;
      8'b0000_1111: bytes = 4'd4;
      8'b0000_0111: bytes = 4'd3;
      8'b0000_0011: bytes = 4'd2;
      8'b0000_0001: bytes = 4'd1;
      default:      bytes = 4'd0; // Irregular or empty
    endcase
  end

  // ------------------------------
  // Word correction
  // ------------------------------
  always_comb
  begin
    o_word = '0;
    // Lane 0 moves to the top byte so a short last word lines up
    for (int i = 0; i < nts_disp_pkg::MASK_W; i++)
    begin
      o_word.data[8*(7-i) +: 8] = i_mac.valid[i] ? i_mac.data[8*i +: 8] : 8'h00;
    end
    o_word.bytes     = bytes;
    o_word.any_valid = |i_mac.valid;
    o_word.sof       = (prev_valid_q == '0) && (&i_mac.valid); // Idle then full word
  end

  // Starts at all ones so the first word after reset is not a frame start
  always_ff @(posedge i_clk or posedge i_areset)
  begin
    if (i_areset)
    begin
      prev_valid_q <= '1;
    end
    else
    begin
      prev_valid_q <= i_mac.valid;
    end
  end

endmodule

//--- src/frame_buffer.sv
// Two-bank frame RAM with registered write port and the dispatch data output stage
`timescale 1ns/1ps

module frame_buffer (
  input  logic                             i_clk,
  input  logic                             i_areset,
  input  nts_disp_pkg::buf_wr_t            i_wr,
  input  nts_disp_pkg::buf_rd_t            i_rd,
  output logic                             o_fifo_rd_valid,
  output logic [nts_disp_pkg::WORD_W-1:0]  o_fifo_rd_data
);

  nts_disp_pkg::buf_wr_t           wr_q;
  logic [nts_disp_pkg::WORD_W-1:0] rd_word;
  logic                            rd_valid_q;
  logic [nts_disp_pkg::WORD_W-1:0] rd_data_q;

  always_ff @(posedge i_clk or posedge i_areset)
  begin
    if (i_areset)
    begin
      wr_q       <= '0;
      rd_valid_q <= 1'b0;
      rd_data_q  <= '0;
    end
    else
    begin
      wr_q       <= i_wr;
      rd_valid_q <= i_rd.emit; // Valid trails emit by one cycle
      if (i_rd.emit)
      begin
        rd_data_q <= rd_word;
      end
    end
  end

  // ------------------------------
  // RAM banks
  // ------------------------------
  for (genvar b = 0; b < 2; b++)
  begin : g_bank
    logic [nts_disp_pkg::WORD_W-1:0]     ram [nts_disp_pkg::BUF_DEPTH];
    logic [nts_disp_pkg::WORD_W-1:0]     rdata;
    logic [nts_disp_pkg::BUF_ADDR_W-1:0] addr;
    logic                                wr_en;

    assign wr_en = wr_q.we && (wr_q.bank == 1'(b));
    assign addr  = wr_en ? wr_q.addr : i_rd.addr; // Writer owns the port

    always_ff @(posedge i_clk)
    begin
      if (wr_en)
      begin
        ram[addr] <= wr_q.data;
      end
      rdata <= ram[addr];
    end
  end

  assign rd_word = i_rd.bank ? g_bank[1].rdata : g_bank[0].rdata;

  assign o_fifo_rd_valid = rd_valid_q;
  assign o_fifo_rd_data  = rd_data_q;

endmodule

//--- src/buffer_fsm.sv
// Ping-pong bank controller for frame receive, readout burst and bank swap
`timescale 1ns/1ps

module buffer_fsm (
  input  logic                          i_clk,
  input  logic                          i_areset,
  input  nts_disp_pkg::rx_word_t        i_word,
  input  logic                          i_good_frame,
  input  logic                          i_bad_frame,
  input  logic                          i_rd_start,
  input  logic                          i_read_discard,
  output nts_disp_pkg::buf_wr_t         o_wr,
  output nts_disp_pkg::buf_rd_t         o_rd,
  output nts_disp_pkg::stat_events_t    o_events,
  output logic                          o_packet_available,
  output logic [3:0]                    o_data_valid,
  output logic                          o_fifo_empty
);

  nts_disp_pkg::buf_state_e            state_q [2];
  nts_disp_pkg::buf_state_e            state_d [2];
  logic [nts_disp_pkg::BUF_ADDR_W-1:0] count_q [2]; // Index of last stored word
  logic [nts_disp_pkg::BUF_ADDR_W-1:0] count_d [2];
  logic [3:0]                          last_q [2];  // Bytes in last word
  logic [3:0]                          last_d [2];
  logic                                cur_q;       // Receive bank
  logic                                cur_d;
  logic [nts_disp_pkg::BUF_ADDR_W-1:0] rd_addr_q;
  logic [nts_disp_pkg::BUF_ADDR_W-1:0] rd_addr_d;
  logic                                empty_q;
  logic                                empty_d;
  logic                                rx_b;
  logic                                out_b;

  assign rx_b  = cur_q;
  assign out_b = ~cur_q;

  always_comb
  begin
    state_d   = state_q;
    count_d   = count_q;
    last_d    = last_q;
    cur_d     = cur_q;
    rd_addr_d = rd_addr_q;
    empty_d   = empty_q;
    o_wr      = '0;
    o_wr.bank = rx_b;
    o_wr.data = i_word.data;
    o_rd      = '0;
    o_rd.bank = out_b;

    // ------------------------------
    // Receive bank
    // ------------------------------
    if (i_bad_frame)
    begin
      state_d[rx_b] = nts_disp_pkg::EMPTY; // Drop whatever is there
      count_d[rx_b] = '0;
      last_d[rx_b]  = '0;
    end
    else
    begin
      case (state_q[rx_b])
        nts_disp_pkg::EMPTY:
        begin
          if (i_word.sof)
          begin
            state_d[rx_b] = nts_disp_pkg::HAS_DATA;
            count_d[rx_b] = '0;
            last_d[rx_b]  = '0;
            o_wr.we       = 1'b1;
          end
        end
        nts_disp_pkg::HAS_DATA:
        begin
          if (&count_q[rx_b])
          begin
            state_d[rx_b] = nts_disp_pkg::ERROR_GENERAL; // Overrun
          end
          else
          begin
            if (i_word.any_valid)
            begin
              count_d[rx_b] = count_q[rx_b] + 1'b1;
              o_wr.we       = 1'b1;
              o_wr.addr     = count_q[rx_b] + 1'b1;
            end
            if (i_good_frame)
            begin
              last_d[rx_b]  = i_word.bytes;
              state_d[rx_b] = nts_disp_pkg::PACKET_RECEIVED;
            end
          end
        end
        nts_disp_pkg::PACKET_RECEIVED:
        begin
          // Hand over once the readout side is free
          if (state_q[out_b] == nts_disp_pkg::EMPTY)
          begin
            state_d[rx_b] = nts_disp_pkg::OUT_INIT_0;
            cur_d         = ~cur_q;
          end
        end
        default: state_d[rx_b] = nts_disp_pkg::EMPTY; // Error recovery
      endcase
    end

    // ------------------------------
    // Readout bank
    // ------------------------------
    if (i_read_discard)
    begin
      state_d[out_b] = nts_disp_pkg::EMPTY;
      empty_d        = 1'b1;
    end
    else
    begin
      case (state_q[out_b])
        nts_disp_pkg::OUT_INIT_0:
        begin
          empty_d = 1'b0;
          if (i_rd_start)
          begin
            state_d[out_b] = nts_disp_pkg::OUT_INIT_1;
          end
        end
        nts_disp_pkg::OUT_INIT_1:
        begin
          rd_addr_d = 1;                // Word 0 is read this cycle
          if (count_q[out_b] == '0)
          begin
            state_d[out_b] = nts_disp_pkg::OUT_FIN_0;
          end
          else
          begin
            state_d[out_b] = nts_disp_pkg::OUT_STREAM;
          end
        end
        nts_disp_pkg::OUT_STREAM:
        begin
          o_rd.addr = rd_addr_q;
          o_rd.emit = 1'b1;              // Emits the word read last cycle
          if (rd_addr_q == count_q[out_b])
          begin
            state_d[out_b] = nts_disp_pkg::OUT_FIN_0;
          end
          else
          begin
            rd_addr_d = rd_addr_q + 1'b1;
          end
        end
        nts_disp_pkg::OUT_FIN_0:
        begin
          o_rd.emit      = 1'b1;
          state_d[out_b] = nts_disp_pkg::OUT_FIN_1;
        end
        nts_disp_pkg::OUT_FIN_1:
          empty_d = 1'b1;               // Wait here for discard
        default: ;
      endcase
    end
  end

  always_ff @(posedge i_clk or posedge i_areset)
  begin
    if (i_areset)
    begin
      for (int i = 0; i < 2; i++)
      begin
        state_q[i] <= nts_disp_pkg::EMPTY;
        count_q[i] <= '0;
        last_q[i]  <= '0;
      end
      cur_q     <= 1'b0;
      rd_addr_q <= '0;
      empty_q   <= 1'b0;
    end
    else
    begin
      state_q   <= state_d;
      count_q   <= count_d;
      last_q    <= last_d;
      cur_q     <= cur_d;
      rd_addr_q <= rd_addr_d;
      empty_q   <= empty_d;
    end
  end

  assign o_packet_available = (state_q[out_b] == nts_disp_pkg::OUT_INIT_0);
  assign o_data_valid       = last_q[out_b];
  assign o_fifo_empty       = empty_q;

  assign o_events = '{
    sof:        1'b0,
    good:       i_good_frame,
    bad:        i_bad_frame,
    dispatched: i_rd_start,
    error:      (state_q[0] == nts_disp_pkg::ERROR_GENERAL) ||
                (state_q[1] == nts_disp_pkg::ERROR_GENERAL),
    bytes:      4'd0
  };

endmodule

//--- src/stat_counters.sv
// Statistics counters and the read-only register port with MSB-read LSB latching
`timescale 1ns/1ps

module stat_counters (
  input  logic                                 i_clk,
  input  logic                                 i_areset,
  input  nts_disp_pkg::stat_events_t           i_events,
  input  logic                                 i_api_cs,
  input  logic [nts_disp_pkg::API_ADDR_W-1:0]  i_api_address,
  output logic [nts_disp_pkg::API_DATA_W-1:0]  o_api_read_data
);

  logic [nts_disp_pkg::CNT_W-1:0]      cnt_q [nts_disp_pkg::NUM_CNT];
  logic [nts_disp_pkg::API_DATA_W-1:0] lsb_q [nts_disp_pkg::NUM_CNT];
  logic [3:0]                          inc [nts_disp_pkg::NUM_CNT];
  logic                                bad_q;
  logic                                hit;
  logic [2:0]                          hit_idx;
  logic                                is_msb;
  logic                                latch_we;

  always_comb
  begin
    inc[nts_disp_pkg::CNT_FRAMES]     = {3'd0, i_events.sof};
    inc[nts_disp_pkg::CNT_GOOD]       = {3'd0, i_events.good};
    inc[nts_disp_pkg::CNT_BAD]        = {3'd0, bad_q};  // One cycle later
    inc[nts_disp_pkg::CNT_DISPATCHED] = {3'd0, i_events.dispatched};
    inc[nts_disp_pkg::CNT_ERROR]      = {3'd0, i_events.error};
    inc[nts_disp_pkg::CNT_BYTES]      = i_events.bytes;
  end

  // ------------------------------
  // Address decode
  // ------------------------------
  always_comb
  begin
    hit = 1'b1;
    case (i_api_address)
      nts_disp_pkg::ADDR_FRAMES_MSB, nts_disp_pkg::ADDR_FRAMES_LSB:
        hit_idx = nts_disp_pkg::CNT_FRAMES;
      nts_disp_pkg::ADDR_GOOD_MSB, nts_disp_pkg::ADDR_GOOD_LSB:
        hit_idx = nts_disp_pkg::CNT_GOOD;
      nts_disp_pkg::ADDR_BAD_MSB, nts_disp_pkg::ADDR_BAD_LSB:
        hit_idx = nts_disp_pkg::CNT_BAD;
      nts_disp_pkg::ADDR_DISPATCHED_MSB, nts_disp_pkg::ADDR_DISPATCHED_LSB:
        hit_idx = nts_disp_pkg::CNT_DISPATCHED;
      nts_disp_pkg::ADDR_ERROR_MSB, nts_disp_pkg::ADDR_ERROR_LSB:
        hit_idx = nts_disp_pkg::CNT_ERROR;
      nts_disp_pkg::ADDR_BYTES_RX_MSB, nts_disp_pkg::ADDR_BYTES_RX_LSB:
        hit_idx = nts_disp_pkg::CNT_BYTES;
      default:
      begin
        hit     = 1'b0;
        hit_idx = '0;
      end
    endcase
  end

  // Every counter MSB sits at an even address
  assign is_msb   = ~i_api_address[0];
  assign latch_we = i_api_cs && hit && is_msb;

  always_comb
  begin
    o_api_read_data = '0;
    if (i_api_cs)
    begin
      if (hit)
      begin
        o_api_read_data = is_msb ? cnt_q[hit_idx][63:32] : lsb_q[hit_idx];
      end
      else
      begin
        case (i_api_address)
          nts_disp_pkg::ADDR_NAME0:   o_api_read_data = nts_disp_pkg::CORE_NAME[63:32];
          nts_disp_pkg::ADDR_NAME1:   o_api_read_data = nts_disp_pkg::CORE_NAME[31:0];
          nts_disp_pkg::ADDR_VERSION: o_api_read_data = nts_disp_pkg::CORE_VERSION;
          default: ;                 // Unmapped reads zero
        endcase
      end
    end
  end

  always_ff @(posedge i_clk or posedge i_areset)
  begin
    if (i_areset)
    begin
      bad_q <= 1'b0;
      for (int i = 0; i < nts_disp_pkg::NUM_CNT; i++)
      begin
        cnt_q[i] <= '0;
        lsb_q[i] <= '0;
      end
    end
    else
    begin
      bad_q <= i_events.bad;
      for (int i = 0; i < nts_disp_pkg::NUM_CNT; i++)
      begin
        cnt_q[i] <= cnt_q[i] + nts_disp_pkg::CNT_W'(inc[i]);
        if (latch_we && (hit_idx == 3'(i)))
        begin
          lsb_q[i] <= cnt_q[i][31:0]; // Snapshot matches the MSB just read
        end
      end
    end
  end

endmodule

//--- src/nts_dispatcher.sv
// Top level of the NTS frame dispatcher core joining front end, banks, FSM and counters
`timescale 1ns/1ps

module nts_dispatcher (
  input  logic                                 i_clk,
  input  logic                                 i_areset,

  // MAC receive
  input  logic [nts_disp_pkg::MASK_W-1:0]      i_rx_data_valid,
  input  logic [nts_disp_pkg::WORD_W-1:0]      i_rx_data,
  input  logic                                 i_rx_good_frame,
  input  logic                                 i_rx_bad_frame,

  // Dispatch side
  output logic                                 o_dispatch_packet_available,
  input  logic                                 i_dispatch_packet_read_discard,
  output logic [3:0]                           o_dispatch_data_valid,
  output logic                                 o_dispatch_fifo_empty,
  input  logic                                 i_dispatch_fifo_rd_start,
  output logic                                 o_dispatch_fifo_rd_valid,
  output logic [nts_disp_pkg::WORD_W-1:0]      o_dispatch_fifo_rd_data,

  // Register port
  input  logic                                 i_api_cs,
  input  logic [nts_disp_pkg::API_ADDR_W-1:0]  i_api_address,
  output logic [nts_disp_pkg::API_DATA_W-1:0]  o_api_read_data
);

  nts_disp_pkg::mac_rx_t      mac;
  nts_disp_pkg::rx_word_t     word;
  nts_disp_pkg::buf_wr_t      wr;
  nts_disp_pkg::buf_rd_t      rd;
  nts_disp_pkg::stat_events_t fsm_events;
  nts_disp_pkg::stat_events_t events;

  assign mac = '{
    data:  i_rx_data,
    valid: i_rx_data_valid,
    good:  i_rx_good_frame,
    bad:   i_rx_bad_frame
  };

  // Front end supplies frame start and bytes, FSM the rest
  assign events = '{
    sof:        word.sof,
    good:       fsm_events.good,
    bad:        fsm_events.bad,
    dispatched: fsm_events.dispatched,
    error:      fsm_events.error,
    bytes:      word.bytes
  };

  rx_frontend u_rx_frontend (
    .i_clk    (i_clk),
    .i_areset (i_areset),
    .i_mac    (mac),
    .o_word   (word)
  );

  buffer_fsm u_buffer_fsm (
    .i_clk              (i_clk),
    .i_areset           (i_areset),
    .i_word             (word),
    .i_good_frame       (mac.good),
    .i_bad_frame        (mac.bad),
    .i_rd_start         (i_dispatch_fifo_rd_start),
    .i_read_discard     (i_dispatch_packet_read_discard),
    .o_wr               (wr),
    .o_rd               (rd),
    .o_events           (fsm_events),
    .o_packet_available (o_dispatch_packet_available),
    .o_data_valid       (o_dispatch_data_valid),
    .o_fifo_empty       (o_dispatch_fifo_empty)
  );

  frame_buffer u_frame_buffer (
    .i_clk           (i_clk),
    .i_areset        (i_areset),
    .i_wr            (wr),
    .i_rd            (rd),
    .o_fifo_rd_valid (o_dispatch_fifo_rd_valid),
    .o_fifo_rd_data  (o_dispatch_fifo_rd_data)
  );

  stat_counters u_stat_counters (
    .i_clk           (i_clk),
    .i_areset        (i_areset),
    .i_events        (events),
    .i_api_cs        (i_api_cs),
    .i_api_address   (i_api_address),
    .o_api_read_data (o_api_read_data)
  );

endmodule

//--- testbench/tb_nts_dispatcher.sv
// Self-checking testbench for the NTS dispatcher core, driving random frames against a queue model
`timescale 1ns/1ps

module tb_nts_dispatcher;

  localparam int CYCLE_LIMIT = 4000; // Whole run needs a few hundred cycles

  localparam logic [63:0] NAME_ASCII    = "NTS-DISP";
  localparam logic [31:0] VERSION_ASCII = "0.02";

  logic        i_clk;
  logic        i_areset;
  logic [7:0]  i_rx_data_valid;
  logic [63:0] i_rx_data;
  logic        i_rx_good_frame;
  logic        i_rx_bad_frame;
  logic        i_dispatch_packet_read_discard;
  logic        i_dispatch_fifo_rd_start;
  logic        i_api_cs;
  logic [11:0] i_api_address;
  logic        o_dispatch_packet_available;
  logic [3:0]  o_dispatch_data_valid;
  logic        o_dispatch_fifo_empty;
  logic        o_dispatch_fifo_rd_valid;
  logic [63:0] o_dispatch_fifo_rd_data;
  logic [31:0] o_api_read_data;

  int          seed = 85;
  int          errors = 0;
  int          cycles = 0;
  bit          discarded = 1'b0; // Set after the first discard

  // Reference model
  logic [63:0] exp_words [$];
  int          exp_len [$];
  int          exp_last [$];
  logic [63:0] m_frames = '0;
  logic [63:0] m_good = '0;
  logic [63:0] m_bad = '0;
  logic [63:0] m_dispatched = '0;
  logic [63:0] m_error = '0;
  logic [63:0] m_bytes = '0;

  nts_dispatcher dut0 (
    .i_clk                          (i_clk),
    .i_areset                       (i_areset),
    .i_rx_data_valid                (i_rx_data_valid),
    .i_rx_data                      (i_rx_data),
    .i_rx_good_frame                (i_rx_good_frame),
    .i_rx_bad_frame                 (i_rx_bad_frame),
    .o_dispatch_packet_available    (o_dispatch_packet_available),
    .i_dispatch_packet_read_discard (i_dispatch_packet_read_discard),
    .o_dispatch_data_valid          (o_dispatch_data_valid),
    .o_dispatch_fifo_empty          (o_dispatch_fifo_empty),
    .i_dispatch_fifo_rd_start       (i_dispatch_fifo_rd_start),
    .o_dispatch_fifo_rd_valid       (o_dispatch_fifo_rd_valid),
    .o_dispatch_fifo_rd_data        (o_dispatch_fifo_rd_data),
    .i_api_cs                       (i_api_cs),
    .i_api_address                  (i_api_address),
    .o_api_read_data                (o_api_read_data)
  );

  always #10 i_clk = ~i_clk;

  always @(posedge i_clk)
  begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT)
    begin
      $display("Timeout: the run did not complete within %0d clock cycles", CYCLE_LIMIT);
      $display("Checks stopped with %0d error(s)", errors);
      $display("Simulation finished: FAIL");
      $finish;
    end
  end

  // ------------------------------
  // Checks
  // ------------------------------
  task automatic compare_value(input string name, input logic [63:0] exp,
                               input logic [63:0] act);
    assert (act === exp)
    else
    begin
      errors++;
      $display("Error at %0t ns: %s expected %h, got %h", $time, name, exp, act);
    end
  endtask

  task automatic require_true(input bit ok, input string what);
    assert (ok)
    else
    begin
      errors++;
      $display("Failure at %0t ns: %s", $time, what);
    end
  endtask

  // Lane 0 ends up in the top byte and dead lanes read as zero
  function automatic logic [63:0] expected_word(input logic [63:0] data, input logic [7:0] mask);
    logic [63:0] w;
    w = '0;
    for (int i = 0; i < 8; i++)
    begin
      w = {w[55:0], (mask[i] ? data[8*i +: 8] : 8'h00)};
    end
    return w;
  endfunction

  // ------------------------------
  // Stimulus
  // ------------------------------
  task automatic send_frame(input int n_words, input int last_bytes, input bit good);
    logic [7:0]  mask;
    logic [63:0] data;
    bit          offered;
    offered = good && (n_words <= nts_disp_pkg::BUF_DEPTH);
    i_rx_data_valid = 8'h00;           // Idle word ahead of the frame
    @(negedge i_clk);
    for (int k = 0; k < n_words; k++)
    begin
      mask = (k == n_words - 1) ? 8'((1 << last_bytes) - 1) : 8'hff;
      data = {32'($random(seed)), 32'($random(seed))};
      i_rx_data       = data;
      i_rx_data_valid = mask;
      i_rx_good_frame = (k == n_words - 1) && good;
      i_rx_bad_frame  = (k == n_words - 1) && !good;
      m_bytes = m_bytes + 64'((k == n_words - 1) ? last_bytes : 8);
      if (offered)
      begin
        exp_words.push_back(expected_word(data, mask));
      end
      @(negedge i_clk);
    end
    i_rx_data_valid = 8'h00;
    i_rx_good_frame = 1'b0;
    i_rx_bad_frame  = 1'b0;
    m_frames++;
    if (good)
    begin
      m_good++;
    end
    else
    begin
      m_bad++;
    end
    if (n_words > nts_disp_pkg::BUF_DEPTH)
    begin
      m_error++;                       // One cycle in the error state
    end
    if (offered)
    begin
      exp_len.push_back(n_words);
      exp_last.push_back(last_bytes);
    end
  endtask

  task automatic random_frame(input bit good);
    int n_words;
    int last_bytes;
    n_words    = 2 + int'($unsigned($random(seed)) % 11);
    last_bytes = 1 + int'($unsigned($random(seed)) % 8);
    send_frame(n_words, last_bytes, good);
  endtask

  task automatic idle_watch(input int n_cycles);
    for (int k = 0; k < n_cycles; k++)
    begin
      @(negedge i_clk);
      compare_value("o_dispatch_packet_available", 64'd0, 64'(o_dispatch_packet_available));
      compare_value("o_dispatch_fifo_empty", 64'(discarded), 64'(o_dispatch_fifo_empty));
      compare_value("o_dispatch_fifo_rd_valid", 64'd0, 64'(o_dispatch_fifo_rd_valid));
    end
  endtask

  // Waits for the offer, bursts the frame out and discards it
  task automatic read_packet();
    int          n_words;
    int          last_bytes;
    int          waited;
    logic [63:0] exp;
    n_words    = exp_len.pop_front();
    last_bytes = exp_last.pop_front();
    waited     = 0;
    while (!o_dispatch_packet_available && waited < 200)
    begin
      compare_value("o_dispatch_fifo_empty", 64'(discarded), 64'(o_dispatch_fifo_empty));
      @(negedge i_clk);
      waited++;
    end
    require_true(o_dispatch_packet_available, "frame was not offered for dispatch");
    compare_value("o_dispatch_data_valid", 64'(last_bytes), 64'(o_dispatch_data_valid));
    i_dispatch_fifo_rd_start = 1'b1;
    m_dispatched++;
    @(negedge i_clk);
    i_dispatch_fifo_rd_start = 1'b0;
    waited = 0;
    while (!o_dispatch_fifo_rd_valid && waited < 20)
    begin
      @(negedge i_clk);
      waited++;
    end
    require_true(o_dispatch_fifo_rd_valid, "read burst did not start after rd_start");
    for (int k = 0; k < n_words; k++)
    begin
      exp = exp_words.pop_front();
      compare_value("o_dispatch_fifo_rd_valid", 64'd1, 64'(o_dispatch_fifo_rd_valid));
      compare_value("o_dispatch_fifo_rd_data", exp, o_dispatch_fifo_rd_data);
      @(negedge i_clk);
    end
    compare_value("o_dispatch_fifo_rd_valid", 64'd0, 64'(o_dispatch_fifo_rd_valid));
    i_dispatch_packet_read_discard = 1'b1;
    @(negedge i_clk);
    i_dispatch_packet_read_discard = 1'b0;
    discarded = 1'b1;
    compare_value("o_dispatch_fifo_empty", 64'd1, 64'(o_dispatch_fifo_empty));
  endtask

  // ------------------------------
  // Register port
  // ------------------------------
  task automatic read_reg(input logic [11:0] addr, output logic [31:0] data);
    i_api_cs      = 1'b1;
    i_api_address = addr;
    #2;
    data = o_api_read_data;
    @(negedge i_clk);                  // MSB read latches the LSB here
    i_api_cs = 1'b0;
  endtask

  task automatic counter_matches(input string name, input logic [11:0] msb_addr,
                                 input logic [63:0] exp);
    logic [31:0] hi;
    logic [31:0] lo;
    read_reg(msb_addr, hi);
    read_reg(msb_addr + 12'd1, lo);
    compare_value(name, exp, {hi, lo});
  endtask

  initial
  begin
    logic [31:0] rd;
    i_clk                          = 1'b0;
    i_areset                       = 1'b1;
    i_rx_data_valid                = 8'h00;
    i_rx_data                      = '0;
    i_rx_good_frame                = 1'b0;
    i_rx_bad_frame                 = 1'b0;
    i_dispatch_packet_read_discard = 1'b0;
    i_dispatch_fifo_rd_start       = 1'b0;
    i_api_cs                       = 1'b0;
    i_api_address                  = '0;
    repeat (4) @(negedge i_clk);
    i_areset = 1'b0;
    @(negedge i_clk);
    compare_value("o_dispatch_fifo_empty", 64'd0, 64'(o_dispatch_fifo_empty));
    compare_value("o_dispatch_packet_available", 64'd0, 64'(o_dispatch_packet_available));
    compare_value("o_dispatch_fifo_rd_valid", 64'd0, 64'(o_dispatch_fifo_rd_valid));

    random_frame(1'b1);                // Single good frame
    read_packet();

    random_frame(1'b0);                // Bad frame, then recovery
    idle_watch(10);
    random_frame(1'b1);
    read_packet();

    // Ping-pong with the second frame waiting for the first discard
    random_frame(1'b1);
    random_frame(1'b1);
    read_packet();
    read_packet();

    send_frame(40, 8, 1'b1);           // Overrun
    idle_watch(10);
    random_frame(1'b1);
    read_packet();

    idle_watch(4);
    read_reg(nts_disp_pkg::ADDR_NAME0, rd);
    compare_value("o_api_read_data name0", 64'(NAME_ASCII[63:32]), 64'(rd));
    read_reg(nts_disp_pkg::ADDR_NAME1, rd);
    compare_value("o_api_read_data name1", 64'(NAME_ASCII[31:0]), 64'(rd));
    read_reg(nts_disp_pkg::ADDR_VERSION, rd);
    compare_value("o_api_read_data version", 64'(VERSION_ASCII), 64'(rd));
    read_reg(12'h030, rd);
    compare_value("o_api_read_data unmapped", 64'd0, 64'(rd));
    counter_matches("frames counter", nts_disp_pkg::ADDR_FRAMES_MSB, m_frames);
    counter_matches("good counter", nts_disp_pkg::ADDR_GOOD_MSB, m_good);
    counter_matches("bad counter", nts_disp_pkg::ADDR_BAD_MSB, m_bad);
    counter_matches("dispatched counter", nts_disp_pkg::ADDR_DISPATCHED_MSB, m_dispatched);
    counter_matches("error counter", nts_disp_pkg::ADDR_ERROR_MSB, m_error);
    counter_matches("bytes counter", nts_disp_pkg::ADDR_BYTES_RX_MSB, m_bytes);

    $display("Checks complete with %0d error(s)", errors);
    if (errors == 0)
    begin
      $display("Simulation finished: PASS");
    end
    else
    begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

//--- src.f
src/nts_disp_pkg.sv
src/rx_frontend.sv
src/frame_buffer.sv
src/buffer_fsm.sv
src/stat_counters.sv
src/nts_dispatcher.sv
testbench/tb_nts_dispatcher.sv

//--- Makefile
# Verilator build and run for the NTS dispatcher testbench

VERILATOR ?= verilator
TOP       ?= tb_nts_dispatcher
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Simulation finished: PASS

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# Fails unless the pass line shows up in the output
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
